// ==== build.f ====
logic/fetch_pkg.sv
logic/mem_delay_timer.sv
logic/instr_rom.sv
logic/fetch_control.sv
logic/pc_sequencer.sv
logic/fetch_top.sv
bench/fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing
TOP       = fetch_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== program.hex ====
// One 32-bit instruction word per line, ROM index 0 first (addi x1, x1, index + 1)
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093
02108093
02208093
02308093
02408093
02508093
02608093
02708093
02808093
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
03008093
03108093
03208093
03308093
03408093
03508093
03608093
03708093
03808093
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093
04008093

// ==== bench/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

    localparam logic [31:0] RESET_PC     = 32'h3000_0000;
    localparam int          ROM_WORDS    = 64;
    localparam int          IW           = $clog2(ROM_WORDS);
    localparam int          READ_LATENCY = 3;
    localparam int          N_TESTS      = 22;
    localparam int          MAX_STALL    = 8;
    localparam int          CYCLE_LIMIT  = N_TESTS * (READ_LATENCY + 3 + MAX_STALL) * 2;
    localparam logic [31:0] SEED         = 32'h3e3e_0580;

    // Strobe kinds and the offset code for a strobe in the handoff cycle
    localparam logic [1:0] NONE  = 2'd0;
    localparam logic [1:0] REDIR = 2'd1;
    localparam logic [1:0] STOP  = 2'd2;
    localparam logic [7:0] AT_HS = 8'hff;

    typedef struct packed {
        logic        rand_ready;
        logic [1:0]  kind;
        logic [31:0] target;
        logic [7:0]  offset;
        logic        twice;
        logic [31:0] exp_pc;
        logic        exp_fault;
    } step_t;

    logic                  clock;
    logic                  reset;
    fetch_pkg::redirect_t  redirect;
    logic                  valid;
    fetch_pkg::fetch_out_t out;
    logic                  ready;
    logic [31:0]           rom_model [0:ROM_WORDS-1];
    logic [31:0]           lfsr;
    int                    cycles = 0;
    int                    err_count = 0;
    int                    check_count = 0;

    // ------------------------------
    // Random ready, strobe, target, offset, second strobe, expected pc and fault
    step_t steps [0:N_TESTS-1] = '{
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0000, 1'b0},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0004, 1'b0},
        '{1'b1, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0008, 1'b0},
        '{1'b1, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_000c, 1'b0},
        '{1'b0, REDIR, 32'h3000_0040, 8'd2,  1'b0, 32'h3000_0010, 1'b0},
        '{1'b0, REDIR, 32'h3000_0080, AT_HS, 1'b0, 32'h3000_0040, 1'b0},
        '{1'b0, REDIR, 32'h3000_0020, 8'd1,  1'b1, 32'h3000_0080, 1'b0},
        '{1'b1, STOP,  32'h0000_0000, 8'd3,  1'b0, 32'h3000_0020, 1'b0},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0020, 1'b0},
        '{1'b0, STOP,  32'h0000_0000, AT_HS, 1'b0, 32'h3000_0024, 1'b0},
        '{1'b1, REDIR, 32'h4000_0000, 8'd2,  1'b0, 32'h3000_0024, 1'b0},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h4000_0000, 1'b1},
        '{1'b0, REDIR, 32'h3000_0022, 8'd2,  1'b0, 32'h4000_0004, 1'b1},
        '{1'b0, REDIR, 32'h3000_00f0, 8'd1,  1'b0, 32'h3000_0022, 1'b1},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_00f0, 1'b0},
        '{1'b0, REDIR, 32'h2fff_fffc, 8'd2,  1'b0, 32'h3000_00f4, 1'b0},
        '{1'b0, REDIR, 32'h3000_00fc, AT_HS, 1'b0, 32'h2fff_fffc, 1'b1},
        '{1'b1, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_00fc, 1'b0},
        '{1'b1, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0100, 1'b1},
        '{1'b0, REDIR, 32'h3000_0000, AT_HS, 1'b0, 32'h3000_0104, 1'b1},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0000, 1'b0},
        '{1'b0, NONE,  32'h0000_0000, 8'd0,  1'b0, 32'h3000_0004, 1'b0}
    };

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .ROM_WORDS   (ROM_WORDS),
        .READ_LATENCY(READ_LATENCY)
    ) UUT (
        .clock   (clock),
        .reset   (reset),
        .redirect(redirect),
        .valid   (valid),
        .out     (out),
        .ready   (ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    initial begin
        step_t                 s;
        int                    cyc;
        int                    stall_run;
        int                    last_rise;
        int                    errs_before;
        logic                  delivered;
        logic                  prev_valid;
        logic                  prev_stalled;
        logic                  prev_handoff;
        fetch_pkg::fetch_out_t prev_out;
        logic [31:0]           index;

        reset        = 1'b1;
        ready        = 1'b0;
        redirect     = '0;
        lfsr         = SEED;
        last_rise    = 0;
        prev_valid   = 1'b0;
        prev_stalled = 1'b0;
        prev_handoff = 1'b0;
        prev_out     = '0;
        $readmemh("program.hex", rom_model);
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int t = 0; t < N_TESTS; t++) begin
            s           = steps[t];
            cyc         = 0;
            stall_run   = 0;
            delivered   = 1'b0;
            errs_before = err_count;
            while (!delivered) begin
                @(negedge clock);
                redirect = '0;
                if (prev_stalled && (!valid || out !== prev_out)) begin
                    $display("At %0t ns the held output changed while ready was low", $time);
                    err_count++;
                end
                if (prev_handoff && valid) begin
                    $display("At %0t ns valid stayed high after a handoff", $time);
                    err_count++;
                end
                // Rise to rise spacing is fixed after an unstalled handoff
                if (valid && !prev_valid) begin
                    if (t > 0 && !steps[t-1].rand_ready) begin
                        compare_field("valid rise gap", 32'(cycles - last_rise),
                                      32'(READ_LATENCY + 3));
                    end
                    last_rise = cycles;
                end
                if (s.rand_ready) begin
                    lfsr  = next_lfsr(lfsr);
                    ready = lfsr[0] || (stall_run >= MAX_STALL);
                end else begin
                    ready = 1'b1;
                end
                if (s.kind != NONE) begin
                    if ((s.offset == AT_HS) ? (valid && ready) : (cyc == int'(s.offset))) begin
                        redirect.redirect = (s.kind == REDIR);
                        redirect.stop     = (s.kind == STOP);
                        redirect.target   = s.target;
                    end else if (s.twice && cyc == int'(s.offset) + 1) begin
                        // Dropped by the DUT while the first strobe is pending
                        redirect.redirect = 1'b1;
                        redirect.target   = s.target + 32'd8;
                    end
                end
                if (valid && !ready) begin
                    stall_run++;
                end
                if (valid && ready) begin
                    index = (s.exp_pc - RESET_PC) >> 2;
                    compare_field("out.pc", out.pc, s.exp_pc);
                    compare_field("out.inst", out.inst,
                                  s.exp_fault ? 32'd0 : rom_model[index[IW-1:0]]);
                    compare_field("out.fault", 32'(out.fault), 32'(s.exp_fault));
                    delivered = 1'b1;
                end
                prev_stalled = valid && !ready;
                prev_handoff = valid && ready;
                prev_valid   = valid;
                prev_out     = out;
                cyc++;
            end
            $display("Test %0d  pc %h  %s", t, s.exp_pc,
                     (err_count == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d checks, %0d errors", N_TESTS, check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_top #(
    parameter logic [31:0] RESET_PC     = 32'h3000_0000,
    parameter int          ROM_WORDS    = 64,
    parameter int          READ_LATENCY = 3
) (
    input  logic                  clock,
    input  logic                  reset,

    input  fetch_pkg::redirect_t  redirect,

    output logic                  valid,
    output fetch_pkg::fetch_out_t out,
    input  logic                  ready
);

    // Read channels between fetch and ROM
    logic               ar_valid;
    logic               ar_ready;
    fetch_pkg::axi_ar_t ar;
    logic               r_valid;
    fetch_pkg::axi_r_t  r;

    logic [31:0]        pc;
    logic               handoff;

    fetch_control u_control (
        .clock   (clock),
        .reset   (reset),
        .ar_valid(ar_valid),
        .ar      (ar),
        .ar_ready(ar_ready),
        .r_valid (r_valid),
        .r       (r),
        .valid   (valid),
        .out     (out),
        .ready   (ready),
        .pc      (pc),
        .handoff (handoff)
    );

    pc_sequencer #(
        .RESET_PC(RESET_PC)
    ) u_pc (
        .clock   (clock),
        .reset   (reset),
        .redirect(redirect),
        .handoff (handoff),
        .pc      (pc)
    );

    instr_rom #(
        .RESET_PC    (RESET_PC),
        .ROM_WORDS   (ROM_WORDS),
        .READ_LATENCY(READ_LATENCY)
    ) u_rom (
        .clock   (clock),
        .reset   (reset),
        .ar_valid(ar_valid),
        .ar      (ar),
        .ar_ready(ar_ready),
        .r_valid (r_valid),
        .r       (r)
    );

endmodule

`default_nettype wire

// ==== logic/pc_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer #(
    parameter logic [31:0] RESET_PC = 32'h3000_0000
) (
    input  logic                 clock,
    input  logic                 reset,

    input  fetch_pkg::redirect_t redirect,
    input  logic                 handoff,

    output logic [31:0]          pc
);

    // One-deep latch of the first strobe since the last handoff
    fetch_pkg::redirect_t pending;
    logic                 pending_active;
    logic                 strobe;
    logic [31:0]          next_pc;

    assign pending_active = pending.redirect || pending.stop;
    assign strobe         = redirect.redirect || redirect.stop;

    // ------------------------------
    // Next address at handoff
    // ------------------------------

    always_comb begin
        if (pending.stop || redirect.stop) begin
            // Refetch the same address
            next_pc = pc;
        end else if (pending.redirect) begin
            next_pc = pending.target;
        end else if (redirect.redirect) begin
            next_pc = redirect.target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (handoff) begin
            pc <= next_pc;
        end
    end

    // ------------------------------
    // Pending request latch
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            pending.redirect <= 1'b0;
            pending.stop     <= 1'b0;
        end else if (handoff) begin
            pending.redirect <= 1'b0;
            pending.stop     <= 1'b0;
        end else if (strobe && !pending_active) begin
            // First one wins and later strobes are dropped
            pending.redirect <= redirect.redirect;
            pending.stop     <= redirect.stop;
        end
    end

    // Target kept with the first strobe
    always_ff @(posedge clock) begin
        if (!handoff && strobe && !pending_active) begin
            pending.target <= redirect.target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_control (
    input  logic                  clock,
    input  logic                  reset,

    // AXI4 read address channel
    output logic                  ar_valid,
    output fetch_pkg::axi_ar_t    ar,
    input  logic                  ar_ready,

    // AXI4 read data channel, always ready
    input  logic                  r_valid,
    input  fetch_pkg::axi_r_t     r,

    // Decode side
    output logic                  valid,
    output fetch_pkg::fetch_out_t out,
    input  logic                  ready,

    input  logic [31:0]           pc,
    output logic                  handoff
);

    typedef enum logic [1:0] {
        REQUEST,
        WAIT_DATA,
        HOLD
    } state_t;

    // Only one read outstanding, so one id is enough
    localparam logic [3:0] FETCH_ID = 4'd0;

    state_t state;
    logic   data_hit;

    // ------------------------------
    // Address channel
    // ------------------------------

    assign ar_valid = (state == REQUEST);

    always_comb begin
        ar.addr  = pc;
        ar.id    = FETCH_ID;
        // Single beat
        ar.len   = 8'd0;
        ar.size  = fetch_pkg::SIZE_WORD;
        ar.burst = fetch_pkg::BURST_FIXED;
    end

    // ------------------------------
    // Sequencing
    // ------------------------------

    assign data_hit = r_valid && (r.id == FETCH_ID);
    assign valid    = (state == HOLD);
    assign handoff  = valid && ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= REQUEST;
        end else begin
            case (state)
                REQUEST: begin
                    if (ar_ready) begin
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_hit) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    // Next fetch starts right after decode takes this one
                    if (ready) begin
                        state <= REQUEST;
                    end
                end
                default: begin
                    state <= REQUEST;
                end
            endcase
        end
    end

    // Output register, held until handoff
    always_ff @(posedge clock) begin
        if (state == WAIT_DATA && data_hit) begin
            out.pc    <= pc;
            out.inst  <= r.data;
            out.fault <= (r.resp != fetch_pkg::RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_rom #(
    parameter logic [31:0] RESET_PC     = 32'h3000_0000,
    parameter int          ROM_WORDS    = 64,
    parameter int          READ_LATENCY = 3
) (
    input  logic               clock,
    input  logic               reset,

    // AXI4 read address channel
    input  logic               ar_valid,
    input  fetch_pkg::axi_ar_t ar,
    output logic               ar_ready,

    // AXI4 read data channel
    output logic               r_valid,
    output fetch_pkg::axi_r_t  r
);

    localparam int          IW        = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;
    localparam logic [31:0] ROM_BYTES = 32'(4 * ROM_WORDS);

    logic [31:0]       mem [0:ROM_WORDS-1];
    logic              accept;
    logic              busy;
    logic              done;
    logic [31:0]       offset;
    logic              hit;
    fetch_pkg::axi_r_t rsp;

    initial begin
        $readmemh("program.hex", mem);
    end

    // ------------------------------
    // Address decode
    // ------------------------------

    assign ar_ready = !busy;
    assign accept   = ar_valid && ar_ready;
    assign offset   = ar.addr - RESET_PC;

    // Word aligned and inside the image
    assign hit = (ar.addr >= RESET_PC)
              && (offset < ROM_BYTES)
              && (ar.addr[1:0] == 2'b00);

    // Response is looked up at accept and held for the timer
    always_ff @(posedge clock) begin
        if (accept) begin
            rsp.id   <= ar.id;
            rsp.last <= 1'b1;
            if (hit) begin
                rsp.data <= mem[offset[IW+1:2]];
                rsp.resp <= fetch_pkg::RESP_OKAY;
            end else begin
                rsp.data <= 32'd0;
                rsp.resp <= fetch_pkg::RESP_SLVERR;
            end
        end
    end

    // ------------------------------
    // Read latency
    // ------------------------------

    mem_delay_timer #(
        .READ_LATENCY(READ_LATENCY)
    ) u_timer (
        .clock(clock),
        .reset(reset),
        .start(accept),
        .busy (busy),
        .done (done)
    );

    assign r_valid = done;
    assign r       = rsp;

endmodule

`default_nettype wire

// ==== logic/mem_delay_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_delay_timer #(
    parameter int READ_LATENCY = 3
) (
    input  logic clock,
    input  logic reset,

    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CW = $clog2(READ_LATENCY + 1);

    logic [CW-1:0] count;

    assign busy = (count != '0);

    // Count runs READ_LATENCY down to zero, done follows the last step
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= (count == CW'(1));
            if (start) begin
                count <= CW'(READ_LATENCY);
            end else if (busy) begin
                count <= count - CW'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // ------------------------------
    // AXI4 read channel payloads
    // ------------------------------

    // Read address channel, 49 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    // Read data channel, 39 bits
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    // ------------------------------
    // Pipeline side payloads
    // ------------------------------

    // Strobe from later stages, only meaningful when redirect or stop is set
    typedef struct packed {
        logic [31:0] target;
        logic        redirect;
        logic        stop;
    } redirect_t;

    // Fetched instruction handed to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        fault;
    } fetch_out_t;

    // Response and burst encodings
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [2:0] SIZE_WORD   = 3'b010;

endpackage

`default_nettype wire
